// File: Makefile
# Verilator simulation of the conv store controller

VERILATOR ?= verilator
TOP       ?= tb_conv_store
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: sim clean

# exit status of the simulation is the test result
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/conv_geom_pkg.sv
package conv_geom_pkg;

  //////////////////////////////////////////////////
  // systolic array geometry

  // rows per array column, one row FIFO each
  localparam int SA_ROWS = 4;
  localparam int SA_COLUMNS = 3;
  localparam int FIFO_NUM = SA_ROWS * SA_COLUMNS;

  //////////////////////////////////////////////////
  // channel and pixel packing

  // channels held by one row FIFO, per mode
  localparam int CH_PER_FIFO_HALF = 16;
  localparam int CH_PER_FIFO_FULL = 32;

  // two channels per ddr word
  localparam int CH_PER_WORD_LOG = 1;
  // 32 pixels along x per word
  localparam int PIXELS_PER_WORD_LOG = 5;

  // channel, row or position count
  typedef logic [15:0] tile_count_t;

  // one-hot read strobes, one bit per row FIFO
  typedef logic [FIFO_NUM-1:0] fifo_sel_t;

endpackage

// File: rtl/conv_store_top.sv
module conv_store_top
  import conv_geom_pkg::*;
  import ddr_store_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  store_mode_t mode,
  input  ddr_addr_t   layer_base_adr,
  input  logic [3:0]  of_in_2pow,
  input  logic [3:0]  ox_in_2pow,
  input  tile_count_t ox_start,
  input  tile_count_t oy_start,
  input  tile_count_t of_start,
  input  tile_count_t pof,
  input  tile_count_t poy,
  input  logic        ddr_cmd_ready,
  input  logic        ddr_wt_data_ready,
  input  ddr_word_t   fifo_data,
  output fifo_sel_t   fifo_rds,
  output ddr_addr_t   store_ddr_base_adr,
  output burst_len_t  store_ddr_length,
  output logic        valid_store_ddr_cmd,
  output ddr_addr_t   conv_out_ddr_adr,
  output ddr_word_t   conv_out_ddr_data,
  output logic        valid_conv_out_ddr_data,
  output logic        conv_store_fin
);

  tile_count_t cmd_row;
  tile_count_t cmd_ch;
  logic        cmd_last;
  logic        burst_done;
  logic        rd_en;
  logic        push;
  logic        word_full;

  //////////////////////////////////////////////////
  // command path

  store_cmd_gen store_cmd_gen_inst (
    .clk                 (clk),
    .reset               (reset),
    .start               (start),
    .ddr_cmd_ready       (ddr_cmd_ready),
    .burst_done          (burst_done),
    .layer_base_adr      (layer_base_adr),
    .of_in_2pow          (of_in_2pow),
    .ox_in_2pow          (ox_in_2pow),
    .ox_start            (ox_start),
    .oy_start            (oy_start),
    .of_start            (of_start),
    .pof                 (pof),
    .poy                 (poy),
    .valid_store_ddr_cmd (valid_store_ddr_cmd),
    .store_ddr_base_adr  (store_ddr_base_adr),
    .store_ddr_length    (store_ddr_length),
    .cmd_row             (cmd_row),
    .cmd_ch              (cmd_ch),
    .cmd_last            (cmd_last)
  );

  //////////////////////////////////////////////////
  // data path

  // the issued command doubles as the burst descriptor
  store_data_mover store_data_mover_inst (
    .clk                     (clk),
    .reset                   (reset),
    .mode                    (mode),
    .cmd_fire                (valid_store_ddr_cmd),
    .cmd_row                 (cmd_row),
    .cmd_ch                  (cmd_ch),
    .cmd_len                 (store_ddr_length),
    .cmd_adr                 (store_ddr_base_adr),
    .cmd_last                (cmd_last),
    .word_full               (word_full),
    .ddr_wt_data_ready       (ddr_wt_data_ready),
    .fifo_rds                (fifo_rds),
    .rd_en                   (rd_en),
    .push                    (push),
    .valid_conv_out_ddr_data (valid_conv_out_ddr_data),
    .conv_out_ddr_adr        (conv_out_ddr_adr),
    .burst_done              (burst_done),
    .conv_store_fin          (conv_store_fin)
  );

  store_word_packer store_word_packer_inst (
    .clk               (clk),
    .reset             (reset),
    .mode              (mode),
    .rd_en             (rd_en),
    .push              (push),
    .fifo_data         (fifo_data),
    .word_full         (word_full),
    .conv_out_ddr_data (conv_out_ddr_data)
  );

endmodule

// File: rtl/ddr_store_pkg.sv
package ddr_store_pkg;

  //////////////////////////////////////////////////
  // ddr word and command format

  localparam int DDR_WORD_W = 512;
  localparam int HALF_WORD_W = 256;

  // upper bound on words per store command
  localparam int CMD_WORDS_MAX = 32;

  typedef logic [DDR_WORD_W-1:0] ddr_word_t;
  typedef logic [HALF_WORD_W-1:0] half_word_t;

  // word address, not byte address
  typedef logic [31:0] ddr_addr_t;
  typedef logic [15:0] burst_len_t;

  //////////////////////////////////////////////////
  // modes and FSM states

  // half: two 256-bit FIFO reads per word, full: one 512-bit read
  typedef enum logic {
    MODE_HALF,
    MODE_FULL
  } store_mode_t;

  typedef enum logic [1:0] {
    CMD_IDLE,
    CMD_ISSUE,
    CMD_WAIT_BURST
  } cmd_state_t;

  typedef enum logic [1:0] {
    MOVE_IDLE,
    MOVE_READ,
    MOVE_PUSH
  } move_state_t;

endpackage

// File: rtl/store_cmd_gen.sv
module store_cmd_gen
  import conv_geom_pkg::*;
  import ddr_store_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        start,
  input  logic        ddr_cmd_ready,
  input  logic        burst_done,
  input  ddr_addr_t   layer_base_adr,
  input  logic [3:0]  of_in_2pow,
  input  logic [3:0]  ox_in_2pow,
  input  tile_count_t ox_start,
  input  tile_count_t oy_start,
  input  tile_count_t of_start,
  input  tile_count_t pof,
  input  tile_count_t poy,
  output logic        valid_store_ddr_cmd,
  output ddr_addr_t   store_ddr_base_adr,
  output burst_len_t  store_ddr_length,
  output tile_count_t cmd_row,
  output tile_count_t cmd_ch,
  output logic        cmd_last
);

  cmd_state_t  state;
  ddr_addr_t   base_q;
  logic [3:0]  of_2pow_q;
  logic [3:0]  ox_2pow_q;
  tile_count_t ox_start_q;
  tile_count_t oy_start_q;
  tile_count_t of_start_q;
  tile_count_t pof_q;
  tile_count_t poy_q;
  tile_count_t row_cnt;
  tile_count_t ch_cnt;
  tile_count_t ch_left;
  burst_len_t  next_len;
  logic        row_end;
  logic        tile_end;
  logic [4:0]  row_shift;
  logic [4:0]  x_shift;
  ddr_addr_t   row_adr;
  ddr_addr_t   x_adr;
  ddr_addr_t   ch_adr;
  ddr_addr_t   next_adr;

  //////////////////////////////////////////////////
  // length and address of the next group

  assign ch_left = pof_q - ch_cnt;
  // a full command covers 64 channels
  assign row_end = ch_left <= tile_count_t'(CMD_WORDS_MAX << CH_PER_WORD_LOG);
  assign next_len = row_end ? burst_len_t'(ch_left >> CH_PER_WORD_LOG)
                            : burst_len_t'(CMD_WORDS_MAX);
  assign tile_end = row_end && (row_cnt == poy_q - 1'b1);

  // one output row spans (channels / 2) * (width / 32) words
  assign row_shift = {1'b0, of_2pow_q} + {1'b0, ox_2pow_q}
                   - 5'(CH_PER_WORD_LOG + PIXELS_PER_WORD_LOG);
  assign x_shift = {1'b0, of_2pow_q} - 5'(CH_PER_WORD_LOG);

  assign row_adr = ddr_addr_t'(oy_start_q + row_cnt) << row_shift;
  assign x_adr = (ddr_addr_t'(ox_start_q) << x_shift) >> PIXELS_PER_WORD_LOG;
  assign ch_adr = ddr_addr_t'(of_start_q + ch_cnt) >> CH_PER_WORD_LOG;
  assign next_adr = base_q + row_adr + x_adr + ch_adr;

  //////////////////////////////////////////////////
  // command FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= CMD_IDLE;
      valid_store_ddr_cmd <= 1'b0;
      cmd_last <= 1'b0;
      row_cnt <= '0;
      ch_cnt <= '0;
    end else begin
      valid_store_ddr_cmd <= 1'b0;
      case (state)
        CMD_IDLE: begin
          if (start) begin
            row_cnt <= '0;
            ch_cnt <= '0;
            state <= CMD_ISSUE;
          end
        end
        CMD_ISSUE: begin
          if (ddr_cmd_ready) begin
            valid_store_ddr_cmd <= 1'b1;
            cmd_last <= tile_end;
            // wrap to the next row after the last group
            if (row_end) begin
              ch_cnt <= '0;
              row_cnt <= row_cnt + 1'b1;
            end else begin
              ch_cnt <= ch_cnt + tile_count_t'(next_len << CH_PER_WORD_LOG);
            end
            state <= CMD_WAIT_BURST;
          end
        end
        CMD_WAIT_BURST: begin
          if (burst_done) begin
            state <= cmd_last ? CMD_IDLE : CMD_ISSUE;
          end
        end
        default: state <= CMD_IDLE;
      endcase
    end
  end

  // tile geometry and command fields
  always_ff @(posedge clk) begin
    if (state == CMD_IDLE && start) begin
      base_q <= layer_base_adr;
      of_2pow_q <= of_in_2pow;
      ox_2pow_q <= ox_in_2pow;
      ox_start_q <= ox_start;
      oy_start_q <= oy_start;
      of_start_q <= of_start;
      pof_q <= pof;
      poy_q <= poy;
    end
    if (state == CMD_ISSUE && ddr_cmd_ready) begin
      store_ddr_base_adr <= next_adr;
      store_ddr_length <= next_len;
      cmd_row <= row_cnt;
      cmd_ch <= ch_cnt;
    end
  end

endmodule

// File: rtl/store_data_mover.sv
module store_data_mover
  import conv_geom_pkg::*;
  import ddr_store_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  store_mode_t mode,
  input  logic        cmd_fire,
  input  tile_count_t cmd_row,
  input  tile_count_t cmd_ch,
  input  burst_len_t  cmd_len,
  input  ddr_addr_t   cmd_adr,
  input  logic        cmd_last,
  input  logic        word_full,
  input  logic        ddr_wt_data_ready,
  output fifo_sel_t   fifo_rds,
  output logic        rd_en,
  output logic        push,
  output logic        valid_conv_out_ddr_data,
  output ddr_addr_t   conv_out_ddr_adr,
  output logic        burst_done,
  output logic        conv_store_fin
);

  move_state_t state;
  store_mode_t mode_q;
  tile_count_t row_q;
  tile_count_t ch_q;
  burst_len_t  len_q;
  burst_len_t  word_cnt;
  logic        last_q;
  // second read of a half-mode word
  logic        half_sel;
  tile_count_t fifo_idx;
  logic        last_word;

  //////////////////////////////////////////////////
  // FIFO select and strobes

  // row y owns FIFOs y*4 .. y*4+3, channel groups fill them in order
  assign fifo_idx = tile_count_t'(row_q * SA_ROWS)
                  + ((mode_q == MODE_HALF) ? (ch_q >> $clog2(CH_PER_FIFO_HALF))
                                           : (ch_q >> $clog2(CH_PER_FIFO_FULL)));

  assign rd_en = (state == MOVE_READ);
  assign fifo_rds = rd_en ? (fifo_sel_t'(1) << fifo_idx) : '0;

  // ddr side takes a word whenever one is ready and it is not stalled
  assign push = word_full && ddr_wt_data_ready;
  assign valid_conv_out_ddr_data = push;

  assign last_word = (word_cnt == len_q - 1'b1);
  assign burst_done = push && last_word;

  //////////////////////////////////////////////////
  // burst FSM

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= MOVE_IDLE;
      half_sel <= 1'b0;
      word_cnt <= '0;
      conv_store_fin <= 1'b0;
    end else begin
      conv_store_fin <= burst_done && last_q;
      case (state)
        MOVE_IDLE: begin
          half_sel <= 1'b0;
          if (cmd_fire) begin
            word_cnt <= '0;
            state <= MOVE_READ;
          end
        end
        MOVE_READ: begin
          if (mode_q == MODE_HALF && !half_sel) begin
            half_sel <= 1'b1;
          end else begin
            half_sel <= 1'b0;
            state <= MOVE_PUSH;
          end
        end
        MOVE_PUSH: begin
          if (push) begin
            word_cnt <= word_cnt + 1'b1;
            state <= last_word ? MOVE_IDLE : MOVE_READ;
          end
        end
        default: state <= MOVE_IDLE;
      endcase
    end
  end

  // burst fields, stepped one channel pair per word
  always_ff @(posedge clk) begin
    if (cmd_fire) begin
      mode_q <= mode;
      row_q <= cmd_row;
      ch_q <= cmd_ch;
      len_q <= cmd_len;
      last_q <= cmd_last;
      conv_out_ddr_adr <= cmd_adr;
    end else if (push) begin
      ch_q <= ch_q + tile_count_t'(1 << CH_PER_WORD_LOG);
      conv_out_ddr_adr <= conv_out_ddr_adr + 1'b1;
    end
  end

endmodule

// File: rtl/store_word_packer.sv
module store_word_packer
  import ddr_store_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  store_mode_t mode,
  input  logic        rd_en,
  input  logic        push,
  input  ddr_word_t   fifo_data,
  output logic        word_full,
  output ddr_word_t   conv_out_ddr_data
);

  // fifo_data carries a requested word this cycle
  logic       rd_d;
  // low half already captured
  logic       first_q;
  half_word_t low_q;
  logic       held_q;
  ddr_word_t  word_q;
  logic       live_full;
  ddr_word_t  live_word;

  // word completes this cycle straight from the FIFO
  assign live_full = rd_d && (mode == MODE_FULL || first_q);
  assign live_word = (mode == MODE_FULL) ? fifo_data
                                         : {fifo_data[HALF_WORD_W-1:0], low_q};

  assign word_full = held_q || live_full;
  assign conv_out_ddr_data = held_q    ? word_q :
                             live_full ? live_word : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_d <= 1'b0;
      first_q <= 1'b0;
      held_q <= 1'b0;
    end else begin
      rd_d <= rd_en;
      if (rd_d && mode == MODE_HALF) begin
        first_q <= !first_q;
      end
      // keep the word while the ddr side stalls
      if (live_full && !push) begin
        held_q <= 1'b1;
      end else if (push) begin
        held_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_d && !first_q) begin
      low_q <= fifo_data[HALF_WORD_W-1:0];
    end
    if (live_full) begin
      word_q <= live_word;
    end
  end

endmodule

// File: tb.f
+incdir+include
rtl/conv_geom_pkg.sv
rtl/ddr_store_pkg.sv
rtl/store_cmd_gen.sv
rtl/store_data_mover.sv
rtl/store_word_packer.sv
rtl/conv_store_top.sv
tests/tb_conv_store.sv

// File: include/tb_store_model.svh
`ifndef TB_STORE_MODEL_SVH
`define TB_STORE_MODEL_SVH

//////////////////////////////////////////////////
// random numbers and FIFO contents

// one xorshift32 step
function automatic logic [31:0] xorshift32(input logic [31:0] x);
  logic [31:0] y;
  y = x ^ (x << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

// read n of FIFO k, every 32-bit lane depends on k, n and the lane
function automatic ddr_word_t fifo_word(input int k, input int n);
  ddr_word_t   w;
  logic [31:0] x;
  x = {8'(k), 16'(n), 8'ha5};
  for (int j = 0; j < DDR_WORD_W / 32; j++) begin
    x = xorshift32(x ^ 32'(j + 1));
    w[j*32 +: 32] = x;
  end
  return w;
endfunction

//////////////////////////////////////////////////
// expected commands, strobes and words

// ddr word address of channel pair c in tile row y
function automatic ddr_addr_t word_addr(input int y, input int c);
  int        row_sh;
  int        x_sh;
  ddr_addr_t row_part;
  ddr_addr_t x_part;
  ddr_addr_t ch_part;
  row_sh = int'(t_of2) - 1 + int'(t_ox2) - 5;
  x_sh = int'(t_of2) - 1;
  row_part = ddr_addr_t'(int'(t_oy_start) + y) << row_sh;
  x_part = (ddr_addr_t'(t_ox_start) << x_sh) >> 5;
  ch_part = ddr_addr_t'(int'(t_of_start) + c) >> 1;
  return t_base + row_part + x_part + ch_part;
endfunction

task automatic build_expected();
  int        cpf;
  int        c;
  int        len;
  int        k;
  ddr_word_t lo;
  ddr_word_t hi;
  cpf = (t_mode == MODE_HALF) ? CH_PER_FIFO_HALF : CH_PER_FIFO_FULL;
  for (int y = 0; y < int'(t_poy); y++) begin
    c = 0;
    while (c < int'(t_pof)) begin
      len = (int'(t_pof) - c) / 2;
      if (len > CMD_WORDS_MAX) begin
        len = CMD_WORDS_MAX;
      end
      exp_cmd_adr.push_back(word_addr(y, c));
      exp_cmd_len.push_back(burst_len_t'(len));
      for (int i = 0; i < len; i++) begin
        // four FIFOs per tile row, filled in channel order
        k = y * 4 + (c + 2 * i) / cpf;
        exp_word_adr.push_back(word_addr(y, c + 2 * i));
        exp_sel.push_back(fifo_sel_t'(1) << k);
        if (t_mode == MODE_FULL) begin
          exp_word_data.push_back(fifo_word(k, model_cnt[k]));
          model_cnt[k] = model_cnt[k] + 1;
        end else begin
          // second read of the pair goes to the upper half
          exp_sel.push_back(fifo_sel_t'(1) << k);
          lo = fifo_word(k, model_cnt[k]);
          hi = fifo_word(k, model_cnt[k] + 1);
          model_cnt[k] = model_cnt[k] + 2;
          exp_word_data.push_back({hi[HALF_WORD_W-1:0], lo[HALF_WORD_W-1:0]});
        end
      end
      c = c + 2 * len;
    end
  end
endtask

`endif

// File: tests/tb_conv_store.sv
module tb_conv_store
  import conv_geom_pkg::*;
  import ddr_store_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [31:0] SEED = 32'd23284;
  localparam int NUM_TILES = 20;
  localparam int TILE_TIMEOUT = 20000;

  logic        clk;
  logic        reset;
  logic        start;
  store_mode_t mode;
  ddr_addr_t   layer_base_adr;
  logic [3:0]  of_in_2pow;
  logic [3:0]  ox_in_2pow;
  tile_count_t ox_start;
  tile_count_t oy_start;
  tile_count_t of_start;
  tile_count_t pof;
  tile_count_t poy;
  logic        ddr_cmd_ready = 1'b0;
  logic        ddr_wt_data_ready = 1'b0;
  ddr_word_t   fifo_data = '0;
  fifo_sel_t   fifo_rds;
  ddr_addr_t   store_ddr_base_adr;
  burst_len_t  store_ddr_length;
  logic        valid_store_ddr_cmd;
  ddr_addr_t   conv_out_ddr_adr;
  ddr_word_t   conv_out_ddr_data;
  logic        valid_conv_out_ddr_data;
  logic        conv_store_fin;

  // current tile
  store_mode_t t_mode;
  ddr_addr_t   t_base;
  logic [3:0]  t_of2;
  logic [3:0]  t_ox2;
  tile_count_t t_ox_start;
  tile_count_t t_oy_start;
  tile_count_t t_of_start;
  tile_count_t t_pof;
  tile_count_t t_poy;

  // expected results in order
  ddr_addr_t  exp_cmd_adr[$];
  burst_len_t exp_cmd_len[$];
  fifo_sel_t  exp_sel[$];
  ddr_addr_t  exp_word_adr[$];
  ddr_word_t  exp_word_data[$];
  int         model_cnt[FIFO_NUM] = '{default: 0};

  // FIFO responder state
  int          fifo_cnt[FIFO_NUM] = '{default: 0};
  logic        rd_pending = 1'b0;
  int          rd_idx = 0;
  logic [31:0] tile_rng = SEED;
  logic [31:0] ready_rng = ~SEED;
  int          words_left = 0;
  logic        tile_open = 1'b0;
  logic        fin_seen = 1'b0;
  logic        word_done_prev = 1'b0;

  `include "tb_store_model.svh"

  conv_store_top conv_store_top_inst (
    .clk                     (clk),
    .reset                   (reset),
    .start                   (start),
    .mode                    (mode),
    .layer_base_adr          (layer_base_adr),
    .of_in_2pow              (of_in_2pow),
    .ox_in_2pow              (ox_in_2pow),
    .ox_start                (ox_start),
    .oy_start                (oy_start),
    .of_start                (of_start),
    .pof                     (pof),
    .poy                     (poy),
    .ddr_cmd_ready           (ddr_cmd_ready),
    .ddr_wt_data_ready       (ddr_wt_data_ready),
    .fifo_data               (fifo_data),
    .fifo_rds                (fifo_rds),
    .store_ddr_base_adr      (store_ddr_base_adr),
    .store_ddr_length        (store_ddr_length),
    .valid_store_ddr_cmd     (valid_store_ddr_cmd),
    .conv_out_ddr_adr        (conv_out_ddr_adr),
    .conv_out_ddr_data       (conv_out_ddr_data),
    .valid_conv_out_ddr_data (valid_conv_out_ddr_data),
    .conv_store_fin          (conv_store_fin)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // error handling and compare tasks

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_addr(input string name, input ddr_addr_t got, input ddr_addr_t exp);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED t=%0d ns %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_len(input string name, input burst_len_t got, input burst_len_t exp);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED t=%0d ns %s got %0d expected %0d", $time, name, got, exp));
    end
  endtask

  task automatic check_word(input string name, input ddr_word_t got, input ddr_word_t exp);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED t=%0d ns %s got %h expected %h", $time, name, got, exp));
    end
  endtask

  task automatic check_sel(input string name, input fifo_sel_t got, input fifo_sel_t exp);
    if (got !== exp) begin
      stop_run($sformatf("CHECK FAILED t=%0d ns %s got %b expected %b", $time, name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // tile stimulus

  function automatic logic [31:0] next_rand();
    tile_rng = xorshift32(tile_rng);
    return tile_rng;
  endfunction

  task automatic pick_tile();
    int cpf;
    t_mode = ((next_rand() % 2) != 0) ? MODE_FULL : MODE_HALF;
    cpf = (t_mode == MODE_HALF) ? CH_PER_FIFO_HALF : CH_PER_FIFO_FULL;
    t_poy = tile_count_t'(1 + next_rand() % 3);
    // even, up to four FIFOs per row
    t_pof = tile_count_t'(2 * (1 + next_rand() % (2 * cpf)));
    t_of2 = 4'(8 + next_rand() % 2);
    t_ox2 = 4'(5 + next_rand() % 4);
    t_ox_start = tile_count_t'(32 * (next_rand() % (1 << (t_ox2 - 5))));
    t_oy_start = tile_count_t'(next_rand() % 64);
    t_of_start = tile_count_t'(2 * (next_rand() % 32));
    t_base = next_rand();
  endtask

  task automatic run_tile();
    int cycles;
    @(posedge clk);
    mode <= t_mode;
    layer_base_adr <= t_base;
    of_in_2pow <= t_of2;
    ox_in_2pow <= t_ox2;
    ox_start <= t_ox_start;
    oy_start <= t_oy_start;
    of_start <= t_of_start;
    pof <= t_pof;
    poy <= t_poy;
    start <= 1'b1;
    tile_open = 1'b1;
    fin_seen = 1'b0;
    @(posedge clk);
    start <= 1'b0;
    cycles = 0;
    while (!fin_seen && cycles < TILE_TIMEOUT) begin
      @(posedge clk);
      cycles++;
    end
    if (!fin_seen) begin
      stop_run("timeout while waiting for conv_store_fin");
    end
  endtask

  initial begin
    reset <= 1'b1;
    start <= 1'b0;
    mode <= MODE_HALF;
    layer_base_adr <= '0;
    of_in_2pow <= 4'd8;
    ox_in_2pow <= 4'd5;
    ox_start <= '0;
    oy_start <= '0;
    of_start <= '0;
    pof <= '0;
    poy <= '0;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    for (int tile = 0; tile < NUM_TILES; tile++) begin
      pick_tile();
      build_expected();
      run_tile();
      // idle gap, anything issued after the finish shows up here
      repeat (3 + next_rand() % 6) @(posedge clk);
    end
    $display("test passed");
    $finish;
  end

  //////////////////////////////////////////////////
  // FIFO responder and ready levels

  always @(posedge clk) begin
    // answer the strobe seen in the last cycle
    if (rd_pending) begin
      fifo_data <= fifo_word(rd_idx, fifo_cnt[rd_idx]);
      fifo_cnt[rd_idx] = fifo_cnt[rd_idx] + 1;
      rd_pending = 1'b0;
    end
    if (reset) begin
      ddr_cmd_ready <= 1'b0;
      ddr_wt_data_ready <= 1'b0;
    end else begin
      // each level high about three cycles in four
      ready_rng = xorshift32(ready_rng);
      ddr_cmd_ready <= ready_rng[1:0] != 2'b00;
      ddr_wt_data_ready <= ready_rng[9:8] != 2'b00;
    end
  end

  //////////////////////////////////////////////////
  // output monitor, mid cycle

  always @(negedge clk) begin
    logic word_done_now;
    word_done_now = 1'b0;
    if (!reset) begin
      if (conv_store_fin) begin
        if (!tile_open) begin
          stop_run("conv_store_fin pulsed with no tile running");
        end else if (!word_done_prev || exp_cmd_adr.size() != 0) begin
          stop_run("conv_store_fin did not follow the last expected word");
        end
        tile_open = 1'b0;
        fin_seen = 1'b1;
      end
      if (valid_store_ddr_cmd) begin
        if (exp_cmd_adr.size() == 0) begin
          stop_run("store command issued with none expected");
        end else if (words_left != 0) begin
          stop_run("store command issued while a burst still had words outstanding");
        end else begin
          check_addr("store_ddr_base_adr", store_ddr_base_adr, exp_cmd_adr.pop_front());
          check_len("store_ddr_length", store_ddr_length, exp_cmd_len.pop_front());
          words_left = int'(store_ddr_length);
        end
      end
      if (fifo_rds != '0) begin
        if (exp_sel.size() == 0) begin
          stop_run("FIFO read strobe with none expected");
        end else begin
          check_sel("fifo_rds", fifo_rds, exp_sel.pop_front());
          for (int k = 0; k < FIFO_NUM; k++) begin
            if (fifo_rds[k]) begin
              rd_idx = k;
            end
          end
          rd_pending = 1'b1;
        end
      end
      if (valid_conv_out_ddr_data) begin
        if (exp_word_adr.size() == 0 || words_left == 0) begin
          stop_run("data word written with none expected");
        end else begin
          check_addr("conv_out_ddr_adr", conv_out_ddr_adr, exp_word_adr.pop_front());
          check_word("conv_out_ddr_data", conv_out_ddr_data, exp_word_data.pop_front());
          words_left--;
          word_done_now = (exp_word_adr.size() == 0);
        end
      end
    end
    word_done_prev = word_done_now;
  end

endmodule
